// File: tb/fetch_cases.txt
// Header: memory key, then the number of steps (hex)
// Steps: nextPC halt stallDMAMem blockInstruction missExpected
5a3c96e1 00000019
00000004 0 0 0 1
00000008 0 0 0 0
0000000c 0 0 0 0
00000010 0 0 0 0
0000003c 1 0 0 0
00000020 0 1 0 0
00000024 0 0 1 0
0000003c 0 0 0 0
00000040 0 0 0 0
00000044 0 0 0 1
00000400 0 0 0 0
00000404 0 0 0 1
00000008 0 0 0 0
0000000c 0 0 0 1
000007fc 0 0 0 0
00000100 1 0 0 1
000007c0 0 0 0 0
000007e0 0 0 0 0
00000000 0 1 0 0
00000044 0 0 0 0
12345670 0 0 0 0
1234567c 0 0 0 1
00000400 0 0 0 0
00000404 0 0 1 1
00000000 0 0 0 0

// File: sim.f
+incdir+design
design/fetch_pkg.sv
design/refill_if.sv
design/program_counter.sv
design/refill_beat_counter.sv
design/icache_miss_fsm.sv
design/icache_array.sv
design/fetch_stage.sv
tb/fetch_stage_asserts.sv
tb/fetch_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the fetch stage testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --timescale 1ns/100ps \
        --top-module fetch_stage_tb -f sim.f -o Vfetch_stage_tb; then
    echo "Verilator build failed"
    exit 1
fi

simOutput=$(./obj_dir/Vfetch_stage_tb 2>&1)
simStatus=$?
echo "$simOutput"

if [ "$simStatus" -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOutput" | grep -qx "Test passed"; then
    exit 0
else
    exit 1
fi

// File: tb/fetch_stage_tb.sv
`timescale 1ns/100ps
`include "fetch_defines.svh"

module fetch_stage_tb;

    // The case file starts with the key and the step count, then five words per step
    localparam int MAX_STEPS      = 32;
    localparam int WORDS_PER_STEP = 5;
    localparam int REQ_TIMEOUT    = 8;
    localparam int FILL_TIMEOUT   = 40;

    logic        clk = 1'b0;
    logic        arstN;
    logic        halt;
    logic        stallDMAMem;
    logic        blockInstruction;
    logic [31:0] nextPC;
    logic        mcDataValid;
    logic [127:0] mcDataIn;
    logic [31:0] instr;
    logic [31:0] pcPlus4;
    logic        instrValid;
    logic        memReq;
    logic [31:0] memAddr;

    logic [31:0] caseMem [0:2 + MAX_STEPS * WORDS_PER_STEP - 1];
    logic [31:0] key;
    // Address the DUT should be fetching right now
    logic [31:0] expectedPC;
    int          seed = 32'hb662;

    always #20 clk = ~clk;

    fetch_stage dut (
        .clk              (clk),
        .arstN            (arstN),
        .halt             (halt),
        .stallDMAMem      (stallDMAMem),
        .blockInstruction (blockInstruction),
        .nextPC           (nextPC),
        .mcDataValid      (mcDataValid),
        .mcDataIn         (mcDataIn),
        .instr            (instr),
        .pcPlus4          (pcPlus4),
        .instrValid       (instrValid),
        .memReq           (memReq),
        .memAddr          (memAddr)
    );

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            failRun($sformatf("MISMATCH %s: got 0x%08h, expected 0x%08h",
                              name, actual, expected));
        end
    endtask

    task automatic waitForMemReq();
        int cycles;
        cycles = 0;
        while (memReq !== 1'b1) begin
            if (cycles >= REQ_TIMEOUT) begin
                failRun("Timed out waiting for memReq to rise after a miss");
            end else begin
                @(posedge clk);
                #2;
                cycles++;
            end
        end
    endtask

    task automatic waitForInstrValid();
        int cycles;
        cycles = 0;
        while (instrValid !== 1'b1) begin
            if (cycles >= FILL_TIMEOUT) begin
                failRun("Timed out waiting for instrValid at the end of a refill");
            end else begin
                @(posedge clk);
                #2;
                cycles++;
            end
        end
    endtask

    // Memory controller model where every word holds its own byte address XOR the key
    // Each beat, the first one too, comes after 0 to 3 idle cycles
    task automatic serveRefill(input logic [31:0] lineAddr);
        int           gap;
        logic [127:0] beatWord;
        for (int beat = 0; beat < `BEATS_PER_LINE; beat++) begin
            gap = $random(seed) & 32'h3;
            repeat (gap) begin
                @(posedge clk);
                #2;
            end
            for (int j = 0; j < `BEAT_WIDTH / 32; j++) begin
                beatWord[j*32 +: 32] = (lineAddr + 32'(beat * 16 + j * 4)) ^ key;
            end
            mcDataValid = 1'b1;
            mcDataIn    = beatWord;
            @(posedge clk);
            #2;
            mcDataValid = 1'b0;
        end
    endtask

    initial begin : memoryModel
        mcDataValid = 1'b0;
        mcDataIn    = '0;
        forever begin
            @(posedge clk);
            #2;
            if (memReq) begin
                serveRefill(memAddr);
            end
        end
    end

    // One fetch step starts and ends 2 ns after a rising edge
    task automatic applyStep(input int step);
        int          base;
        logic [31:0] stepNextPC;
        logic        holdPC;
        logic        missExpected;
        base         = 2 + step * WORDS_PER_STEP;
        stepNextPC   = caseMem[base];
        holdPC       = caseMem[base+1][0] | caseMem[base+2][0] | caseMem[base+3][0];
        missExpected = caseMem[base+4][0];
        nextPC           = stepNextPC;
        halt             = caseMem[base+1][0];
        stallDMAMem      = caseMem[base+2][0];
        blockInstruction = caseMem[base+3][0];
        if (missExpected) begin
            checkValue("instrValid", 32'(instrValid), 32'd0);
            waitForMemReq();
            // The request names the start of the 64-byte line
            checkValue("memAddr", memAddr, expectedPC & ~32'h3f);
            waitForInstrValid();
        end else begin
            checkValue("instrValid", 32'(instrValid), 32'd1);
            checkValue("memReq", 32'(memReq), 32'd0);
        end
        checkValue("instr", instr, expectedPC ^ key);
        checkValue("pcPlus4", pcPlus4, expectedPC + 32'd4);
        @(posedge clk);
        #2;
        // A held PC keeps the old address whatever nextPC was
        if (!holdPC) begin
            expectedPC = stepNextPC;
        end
    endtask

    initial begin : mainFlow
        int stepCount;
        arstN            = 1'b0;
        halt             = 1'b0;
        stallDMAMem      = 1'b0;
        blockInstruction = 1'b0;
        nextPC           = '0;
        $readmemh("tb/fetch_cases.txt", caseMem);
        key       = caseMem[0];
        stepCount = caseMem[1];
        if (stepCount < 1 || stepCount > MAX_STEPS) begin
            failRun("The case file gives no usable step count");
        end
        repeat (16) @(posedge clk);
        #2;
        arstN = 1'b1;
        // Reset state before the first edge out of reset
        checkValue("memReq", 32'(memReq), 32'd0);
        checkValue("instrValid", 32'(instrValid), 32'd0);
        checkValue("pcPlus4", pcPlus4, `RESET_PC + 32'd4);
        expectedPC = `RESET_PC;
        for (int step = 0; step < stepCount; step++) begin
            applyStep(step);
        end
        if (dut.uAsserts.failCount != 0) begin
            failRun("A bound assertion on the fetch stage failed during the run");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// File: tb/fetch_stage_asserts.sv
`timescale 1ns/100ps

module fetch_stage_asserts (
    input logic        clk,
    input logic        arstN,
    input logic        halt,
    input logic        stallDMAMem,
    input logic        blockInstruction,
    input logic        mcDataValid,
    input logic        instrValid,
    input logic        memReq,
    input logic [31:0] memAddr,
    input logic [31:0] currPC
);

    // Number of assertion failures seen so far
    int failCount = 0;

    // Until the first beat shows up the request and its address must both hold
    assert property (@(posedge clk) disable iff (!arstN)
        (memReq && !mcDataValid) |=> (memReq && $stable(memAddr)))
    else begin
        failCount++;
        $error("memReq dropped or memAddr moved before the first beat arrived");
    end

    // A line is only requested while the current PC misses
    assert property (@(posedge clk) disable iff (!arstN)
        !(memReq && instrValid))
    else begin
        failCount++;
        $error("memReq was high while instrValid was high");
    end

    // Any of the three hold sources freezes the PC on the following edge
    assert property (@(posedge clk) disable iff (!arstN)
        (halt || stallDMAMem || blockInstruction) |=> $stable(currPC))
    else begin
        failCount++;
        $error("PC moved while a stall was active");
    end

endmodule

bind fetch_stage fetch_stage_asserts uAsserts (
    .clk              (clk),
    .arstN            (arstN),
    .halt             (halt),
    .stallDMAMem      (stallDMAMem),
    .blockInstruction (blockInstruction),
    .mcDataValid      (mcDataValid),
    .instrValid       (instrValid),
    .memReq           (memReq),
    .memAddr          (memAddr),
    .currPC           (currPC)
);

// File: design/fetch_stage.sv
`timescale 1ns/100ps
`include "fetch_defines.svh"

module fetch_stage
    import fetch_pkg::*;
(
    input  logic                   clk,
    input  logic                   arstN,
    // Stall sources from the rest of the pipeline
    input  logic                   halt,
    input  logic                   stallDMAMem,
    input  logic                   blockInstruction,
    // Next fetch address chosen outside this stage
    input  logic [31:0]            nextPC,
    // Refill beats from the memory controller
    input  logic                   mcDataValid,
    input  logic [`BEAT_WIDTH-1:0] mcDataIn,
    // Results for the decode stage
    output logic [31:0]            instr,
    output logic [31:0]            pcPlus4,
    output logic                   instrValid,
    // Line request to the memory controller
    output logic                   memReq,
    output logic [31:0]            memAddr
);

    fetchAddrT currPC;
    logic      hit;

    refill_if rif ();

    // Beat data enters the refill path unchanged
    assign rif.beatData = mcDataIn;

    program_counter uPC (
        .clk              (clk),
        .arstN            (arstN),
        .halt             (halt),
        .stallDMAMem      (stallDMAMem),
        .blockInstruction (blockInstruction),
        .hit              (hit),
        .nextPC           (nextPC),
        .currPC           (currPC),
        .pcPlus4          (pcPlus4)
    );

    refill_beat_counter uBeatCounter (
        .clk   (clk),
        .arstN (arstN),
        .rif   (rif.counter)
    );

    icache_miss_fsm uMissFsm (
        .clk         (clk),
        .arstN       (arstN),
        .mcDataValid (mcDataValid),
        .hit         (hit),
        .currPC      (currPC),
        .memReq      (memReq),
        .memAddr     (memAddr),
        .rif         (rif.fsm)
    );

    icache_array uCache (
        .clk    (clk),
        .arstN  (arstN),
        .currPC (currPC),
        .instr  (instr),
        .hit    (hit),
        .rif    (rif.cache)
    );

    // The word on instr is usable exactly when the current PC hits
    assign instrValid = hit;

endmodule

// File: design/icache_array.sv
`timescale 1ns/100ps
`include "fetch_defines.svh"

module icache_array
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  fetchAddrT   currPC,
    output logic [31:0] instr,
    output logic        hit,
    refill_if.cache     rif
);

    // Line storage holds one entry per index
    logic [`LINE_WIDTH-1:0] dataMem [`FETCH_LINES];
    logic [`TAG_WIDTH-1:0]  tagMem  [`FETCH_LINES];
    logic [`FETCH_LINES-1:0] validBits;

    // Beats of the line under refill are gathered here before the commit
    logic [`LINE_WIDTH-1:0] lineBuffer;

    // Entry selected by the current PC
    logic [`LINE_WIDTH-1:0] readLine;
    logic [`TAG_WIDTH-1:0]  readTag;
    logic                   readValid;

    // Beat zero holds the lowest addressed words, so it lands in the low bits
    // of the line and word n of the line sits at bits n*32 upward
    always_ff @(posedge clk) begin
        if (rif.beatAccept) begin
            lineBuffer[rif.beatCount * `BEAT_WIDTH +: `BEAT_WIDTH] <= rif.beatData;
        end
    end

    // Data and tag are written together when the controller commits the line
    always_ff @(posedge clk) begin
        if (rif.lineWrite) begin
            dataMem[rif.refillIndex] <= lineBuffer;
            tagMem[rif.refillIndex]  <= rif.refillTag;
        end
    end

    // Every line starts empty and becomes valid once its refill is committed
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validBits <= '0;
        end else if (rif.lineWrite) begin
            validBits[rif.refillIndex] <= 1'b1;
        end
    end

    // Direct-mapped lookup with the index field of the PC
    assign readLine  = dataMem[currPC.fields.index];
    assign readTag   = tagMem[currPC.fields.index];
    assign readValid = validBits[currPC.fields.index];

    // A hit needs a valid entry whose stored tag matches the PC tag
    assign hit = readValid && (readTag == currPC.fields.tag);

    // Pick the addressed word out of the line
    assign instr = readLine[currPC.fields.wordOffset * `INSTR_WIDTH +: `INSTR_WIDTH];

endmodule

// File: design/icache_miss_fsm.sv
`timescale 1ns/100ps
`include "fetch_defines.svh"

module icache_miss_fsm
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  logic        mcDataValid,
    input  logic        hit,
    input  fetchAddrT   currPC,
    output logic        memReq,
    output logic [31:0] memAddr,
    refill_if.fsm       rif
);

    missStateT currState;
    missStateT nextState;

    // Tag and index of the line being refilled, captured when the miss is seen
    logic [`TAG_WIDTH-1:0]   missTag;
    logic [`INDEX_WIDTH-1:0] missIndex;
    fetchAddrT               lineAddr;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            currState <= IDLE;
        end else begin
            currState <= nextState;
        end
    end

    // The PC does not move during a miss, but the target is latched anyway
    // so that memAddr is guaranteed stable for the whole request
    always_ff @(posedge clk) begin
        if (currState == IDLE && !hit) begin
            missTag   <= currPC.fields.tag;
            missIndex <= currPC.fields.index;
        end
    end

    always_comb begin
        nextState = currState;
        case (currState)
            IDLE: begin
                if (!hit) begin
                    nextState = REQUEST;
                end
            end
            // The first valid beat is taken here, so FILL only sees the rest
            REQUEST: begin
                if (mcDataValid) begin
                    nextState = FILL;
                end
            end
            FILL: begin
                if (mcDataValid && rif.lastBeat) begin
                    nextState = WRITE;
                end
            end
            WRITE: begin
                nextState = IDLE;
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    // Line-aligned address of the missing line, word and byte offsets zero
    always_comb begin
        lineAddr                   = '0;
        lineAddr.fields.tag        = missTag;
        lineAddr.fields.index      = missIndex;
    end

    assign memReq  = (currState == REQUEST);
    assign memAddr = lineAddr.raw;

    // Every valid beat during REQUEST or FILL is taken since the stage never pushes back
    assign rif.beatAccept  = mcDataValid && (currState == REQUEST || currState == FILL);
    assign rif.lineWrite   = (currState == WRITE);
    assign rif.refillTag   = missTag;
    assign rif.refillIndex = missIndex;

endmodule

// File: design/refill_beat_counter.sv
`timescale 1ns/100ps
`include "fetch_defines.svh"

module refill_beat_counter (
    input logic    clk,
    input logic    arstN,
    refill_if.counter rif
);

    // Index of the final beat of a line
    localparam logic [`BEAT_COUNT_WIDTH-1:0] LAST_BEAT = `BEAT_COUNT_WIDTH'(`BEATS_PER_LINE - 1);

    // beatCount is the number of beats taken so far in this line
    // It also names the slot that the beat arriving now goes into
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rif.beatCount <= '0;
        end else if (rif.beatAccept) begin
            if (rif.lastBeat) begin
                // Line complete so the next refill starts at slot zero again
                rif.beatCount <= '0;
            end else begin
                rif.beatCount <= rif.beatCount + 1'b1;
            end
        end
    end

    // High while the next accepted beat would fill the line
    assign rif.lastBeat = (rif.beatCount == LAST_BEAT);

endmodule

// File: design/program_counter.sv
`timescale 1ns/100ps
`include "fetch_defines.svh"

module program_counter
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  logic        halt,
    input  logic        stallDMAMem,
    input  logic        blockInstruction,
    input  logic        hit,
    input  logic [31:0] nextPC,
    output fetchAddrT   currPC,
    output logic [31:0] pcPlus4
);

    logic advance;

    // The PC moves only when nobody holds it and the current word is in the cache
    // A miss keeps the PC on the missing address until the refill lands
    assign advance = !halt && !stallDMAMem && !blockInstruction && hit;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            currPC.raw <= `RESET_PC;
        end else if (advance) begin
            currPC.raw <= nextPC;
        end
    end

    // Sequential path for the next stage, valid in the same cycle as the PC
    assign pcPlus4 = currPC.raw + 32'd4;

endmodule

// File: design/refill_if.sv
`timescale 1ns/100ps
`include "fetch_defines.svh"

interface refill_if;

    // Driven by the miss controller
    logic                          beatAccept;
    logic                          lineWrite;
    logic [`INDEX_WIDTH-1:0]       refillIndex;
    logic [`TAG_WIDTH-1:0]         refillTag;

    // Beat data comes straight from the memory controller port
    logic [`BEAT_WIDTH-1:0]        beatData;

    // Driven by the beat counter
    logic [`BEAT_COUNT_WIDTH-1:0]  beatCount;
    logic                          lastBeat;

    modport fsm (output beatAccept, lineWrite, refillIndex, refillTag, input lastBeat);

    modport counter (input beatAccept, output beatCount, lastBeat);

    modport cache (input beatAccept, lineWrite, refillIndex, refillTag, beatData, beatCount);

endinterface

// File: design/fetch_pkg.sv
`include "fetch_defines.svh"

package fetch_pkg;

    // A fetch address is either a plain word or split into cache fields
    // The tag sits in the top bits and the byte offset in the bottom two
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [`TAG_WIDTH-1:0]         tag;
            logic [`INDEX_WIDTH-1:0]       index;
            logic [`WORD_OFFSET_WIDTH-1:0] wordOffset;
            logic [`BYTE_OFFSET_WIDTH-1:0] byteOffset;
        } fields;
    } fetchAddrT;

    // States of the miss controller
    // IDLE waits for a miss
    // REQUEST holds the line request until the first beat shows up
    // FILL takes the remaining beats
    // WRITE commits the line into the cache storage
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        REQUEST = 2'd1,
        FILL    = 2'd2,
        WRITE   = 2'd3
    } missStateT;

endpackage

// File: design/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Number of lines in the direct-mapped instruction cache
`define FETCH_LINES 16

// Instruction words held in one cache line
`define WORDS_PER_LINE 16

// Width of one instruction word
`define INSTR_WIDTH 32

// One line is the whole set of instruction words
`define LINE_WIDTH (`WORDS_PER_LINE * `INSTR_WIDTH)

// Refill beats arrive from the memory controller at this width
`define BEAT_WIDTH 128
`define BEATS_PER_LINE 4
`define BEAT_COUNT_WIDTH 2

// Field widths of a fetch address, which together make 32 bits
`define TAG_WIDTH 22
`define INDEX_WIDTH 4
`define WORD_OFFSET_WIDTH 4
`define BYTE_OFFSET_WIDTH 2

// The PC starts here after reset
`define RESET_PC 32'h0000_0000

`endif
